//--- i2c_bus_pkg.sv
package i2c_bus_pkg;

    // Bits in one I2C data or address byte
    localparam int BITS_PER_BYTE = 8;

    // Transfer FSM states, 4-bit encoding
    typedef enum logic [3:0] {
        IDLE           = 4'b0000,
        START          = 4'b0001,
        ADDRESS        = 4'b0010,
        READ_ACK       = 4'b0011,   // Slave answer to the address byte
        WRITE_DATA     = 4'b0100,
        READ_LATER_ACK = 4'b0101,   // Slave answer to a data byte
        READ_DATA      = 4'b0110,
        WRITE_ACK      = 4'b0111,   // Master answer to a received byte
        STOP           = 4'b1001
    } i2c_state_e;

    // --------------------
    // Open-drain line drive, 1 pulls the line low
    typedef struct packed {
        logic sda_oe;
        logic scl_oe;
    } i2c_line_t;

    // --------------------
    // One-core-clock pulses on SCL transitions
    typedef struct packed {
        logic rise;
        logic fall;
    } scl_edge_t;

endpackage

//--- i2c_byte_fifo.sv
`timescale 1ns/1ps

module i2c_byte_fifo
    import i2c_xfer_pkg::*;
#(
    parameter int  DEPTH     = 4,
    parameter type payload_t = i2c_byte_t
) (
    input  logic        i2c_core_clk_i,
    input  logic        reset_ni,
    input  logic        push_i,
    input  payload_t    data_i,
    input  logic        pop_i,
    output payload_t    data_o,         // Head entry, no read latency
    output buf_status_t status_o
);

    localparam int               PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int               CNT_W    = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    assign full    = (count_q == CNT_FULL);
    assign empty   = (count_q == '0);
    assign do_push = push_i & ~full;    // Push on full is dropped
    assign do_pop  = pop_i & ~empty;    // Pop on empty is dropped

    // Storage
    always_ff @(posedge i2c_core_clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // --------------------
    // Pointers and occupancy
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign data_o         = mem_q[rd_ptr_q];
    assign status_o.full  = full;
    assign status_o.empty = empty;
    assign status_o.level = LEVEL_W'(count_q);

endmodule

//--- i2c_master_fsm.sv
`timescale 1ns/1ps

module i2c_master_fsm
    import i2c_bus_pkg::*;
    import i2c_xfer_pkg::*;
#(
    parameter int RX_DEPTH = 4
) (
    input  logic        i2c_core_clk_i,
    input  logic        reset_ni,
    input  logic        start_i,
    input  i2c_cmd_t    cmd_i,
    input  logic        sda_i,          // Resolved SDA level
    input  logic        scl_i,          // Resolved SCL level
    input  scl_edge_t   edge_i,
    input  i2c_byte_t   tx_data_i,      // Head of the transmit buffer
    input  buf_status_t tx_status_i,
    input  buf_status_t rx_status_i,
    output logic        tx_pop_o,
    output logic        rx_push_o,
    output i2c_byte_t   rx_data_o,
    output logic        run_o,          // Keep SCL running
    output logic        sda_oe_o,       // 1 pulls SDA low
    output logic        busy_o,
    output logic        nack_o          // Sticky until next start
);

    localparam int                 CNT_W    = $clog2(BITS_PER_BYTE);
    localparam logic [CNT_W-1:0]   LAST_BIT = CNT_W'(BITS_PER_BYTE - 1);
    localparam logic [LEVEL_W-1:0] RX_LIMIT = LEVEL_W'(RX_DEPTH);

    i2c_state_e       state_q;
    i2c_state_e       state_nxt;
    logic [CNT_W-1:0] bit_cnt_q;        // Falling edges within a byte
    i2c_byte_t        shift_q;
    i2c_cmd_t         cmd_q;
    logic             to_read_q;        // Next slot is a read byte, or master ACK
    logic             to_write_q;       // Next slot is a write byte
    logic             nack_q;
    logic             accept;
    logic             ack_slot;
    logic             data_slot;
    logic             byte_done;
    logic             rx_room;

    assign accept    = (state_q == IDLE) & start_i;
    assign ack_slot  = (state_q == READ_ACK) | (state_q == READ_LATER_ACK);
    assign data_slot = (state_q == ADDRESS) | (state_q == WRITE_DATA) |
                       (state_q == READ_DATA);
    assign byte_done = edge_i.fall & (bit_cnt_q == LAST_BIT);
    assign rx_room   = (rx_status_i.level < RX_LIMIT);

    // Pop the next byte only when the slave ACKed and more data waits
    assign tx_pop_o  = ack_slot & edge_i.rise & ~sda_i & ~cmd_q.rw & ~tx_status_i.empty;
    assign rx_push_o = (state_q == READ_DATA) & byte_done;
    assign rx_data_o = shift_q;

    // --------------------
    // State register
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            IDLE:           if (start_i) state_nxt = START;
            START:          if (edge_i.fall) state_nxt = ADDRESS;    // SCL low after START
            ADDRESS:        if (byte_done) state_nxt = READ_ACK;
            WRITE_DATA:     if (byte_done) state_nxt = READ_LATER_ACK;
            READ_DATA:      if (byte_done) state_nxt = WRITE_ACK;
            READ_ACK,
            READ_LATER_ACK: begin
                if (edge_i.fall) begin
                    if (to_read_q) begin
                        state_nxt = READ_DATA;
                    end else if (to_write_q) begin
                        state_nxt = WRITE_DATA;
                    end else begin
                        state_nxt = STOP;   // NACK, empty TX or full RX
                    end
                end
            end
            WRITE_ACK:      if (edge_i.fall) state_nxt = to_read_q ? READ_DATA : STOP;
            STOP:           if (edge_i.rise) state_nxt = IDLE;
            default:        state_nxt = IDLE;
        endcase
    end

    // --------------------
    // Bit counter, ACK flags and NACK status
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            bit_cnt_q  <= '0;
            to_read_q  <= 1'b0;
            to_write_q <= 1'b0;
            nack_q     <= 1'b0;
        end else begin
            if (!data_slot) begin
                bit_cnt_q <= '0;
            end else if (edge_i.fall) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;  // Wraps to 0 at end of byte
            end

            if (ack_slot) begin
                if (edge_i.rise) begin
                    to_read_q  <= ~sda_i & cmd_q.rw & rx_room;
                    to_write_q <= tx_pop_o;
                end
            end else if (state_q == WRITE_ACK) begin
                // Decision frozen while SCL is high
                if (!scl_i) begin
                    to_read_q <= rx_room;
                end
                to_write_q <= 1'b0;
            end else begin
                to_read_q  <= 1'b0;
                to_write_q <= 1'b0;
            end

            if (accept) begin
                nack_q <= 1'b0;
            end else if (ack_slot && edge_i.rise && sda_i) begin
                nack_q <= 1'b1;
            end
        end
    end

    // --------------------
    // Command latch and shift register
    always_ff @(posedge i2c_core_clk_i) begin
        if (accept) begin
            cmd_q <= cmd_i;
        end

        if (state_q == START && edge_i.fall) begin
            shift_q <= i2c_byte_t'(cmd_q);              // Address byte, rw in bit 0
        end else if (tx_pop_o) begin
            shift_q <= tx_data_i;
        end else if (state_q == READ_DATA && edge_i.rise) begin
            shift_q <= {shift_q[BITS_PER_BYTE-2:0], sda_i};
        end else if ((state_q == ADDRESS || state_q == WRITE_DATA) &&
                     edge_i.fall && !byte_done) begin
            shift_q <= {shift_q[BITS_PER_BYTE-2:0], 1'b0}; // Next bit while SCL low
        end
    end

    // SDA drive per state
    always_comb begin
        case (state_q)
            START:      sda_oe_o = 1'b1;                    // SDA falls with SCL high
            ADDRESS,
            WRITE_DATA: sda_oe_o = ~shift_q[BITS_PER_BYTE-1];
            WRITE_ACK:  sda_oe_o = to_read_q;               // Low = ACK
            STOP:       sda_oe_o = 1'b1;                    // Released in IDLE after SCL rises
            default:    sda_oe_o = 1'b0;
        endcase
    end

    assign run_o  = (state_q != IDLE);
    assign busy_o = (state_q != IDLE);
    assign nack_o = nack_q;

endmodule

//--- i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top
    import i2c_bus_pkg::*;
    import i2c_xfer_pkg::*;
#(
    parameter int CLK_DIV  = 4,
    parameter int TX_DEPTH = 4,
    parameter int RX_DEPTH = 4
) (
    input  logic      i2c_core_clk_i,
    input  logic      reset_ni,
    // Host side
    input  logic      tx_push_i,
    input  i2c_byte_t tx_data_i,
    input  logic      start_i,
    input  i2c_cmd_t  cmd_i,
    input  logic      rx_pop_i,
    output i2c_byte_t rx_data_o,
    output logic      rx_valid_o,
    output logic      tx_full_o,
    output logic      busy_o,
    output logic      nack_o,
    // Bus side
    input  logic      sda_i,
    input  logic      scl_i,
    output i2c_line_t line_o
);

    i2c_byte_t   tx_head;
    i2c_byte_t   rx_byte;
    buf_status_t tx_status;
    buf_status_t rx_status;
    scl_edge_t   scl_edge;
    logic        tx_pop;
    logic        rx_push;
    logic        run;
    logic        scl_drive;
    logic        sda_oe;

    // --------------------
    // Write path, host fills and FSM drains
    i2c_byte_fifo #(
        .DEPTH     (TX_DEPTH),
        .payload_t (i2c_byte_t)
    ) tx_fifo (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .push_i         (tx_push_i),
        .data_i         (tx_data_i),
        .pop_i          (tx_pop),
        .data_o         (tx_head),
        .status_o       (tx_status)
    );

    // Read path, FSM fills and host drains
    i2c_byte_fifo #(
        .DEPTH     (RX_DEPTH),
        .payload_t (i2c_byte_t)
    ) rx_fifo (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .push_i         (rx_push),
        .data_i         (rx_byte),
        .pop_i          (rx_pop_i),
        .data_o         (rx_data_o),
        .status_o       (rx_status)
    );

    // --------------------
    i2c_scl_gen #(
        .CLK_DIV (CLK_DIV)
    ) scl_gen (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .run_i          (run),
        .scl_i          (scl_i),
        .scl_drive_o    (scl_drive),
        .edge_o         (scl_edge)
    );

    i2c_master_fsm #(
        .RX_DEPTH (RX_DEPTH)
    ) master_fsm (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .start_i        (start_i),
        .cmd_i          (cmd_i),
        .sda_i          (sda_i),
        .scl_i          (scl_i),
        .edge_i         (scl_edge),
        .tx_data_i      (tx_head),
        .tx_status_i    (tx_status),
        .rx_status_i    (rx_status),
        .tx_pop_o       (tx_pop),
        .rx_push_o      (rx_push),
        .rx_data_o      (rx_byte),
        .run_o          (run),
        .sda_oe_o       (sda_oe),
        .busy_o         (busy_o),
        .nack_o         (nack_o)
    );

    assign line_o.sda_oe = sda_oe;
    assign line_o.scl_oe = scl_drive;
    assign rx_valid_o    = ~rx_status.empty;    // Head entry present
    assign tx_full_o     = tx_status.full;

endmodule

//--- i2c_scl_gen.sv
`timescale 1ns/1ps

module i2c_scl_gen
    import i2c_bus_pkg::*;
#(
    parameter int CLK_DIV = 4           // Core clocks per SCL half period
) (
    input  logic      i2c_core_clk_i,
    input  logic      reset_ni,
    input  logic      run_i,            // Clock SCL while high
    input  logic      scl_i,            // Resolved SCL line level
    output logic      scl_drive_o,      // 1 pulls SCL low
    output scl_edge_t edge_o
);

    localparam int               DIV_W    = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

    logic [DIV_W-1:0] div_cnt_q;
    logic             scl_phase_q;      // 1 = SCL released
    logic             scl_prev_q;

    // --------------------
    // Half-period divider
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            div_cnt_q   <= '0;
            scl_phase_q <= 1'b1;
        end else if (!run_i) begin
            div_cnt_q   <= '0;          // Rest with SCL high
            scl_phase_q <= 1'b1;
        end else if (div_cnt_q == DIV_LAST) begin
            div_cnt_q   <= '0;
            scl_phase_q <= ~scl_phase_q;
        end else begin
            div_cnt_q   <= div_cnt_q + 1'b1;
        end
    end

    assign scl_drive_o = ~scl_phase_q;

    // --------------------
    // Edge detect on the real line level
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            scl_prev_q <= 1'b1;         // Idle bus is high
        end else begin
            scl_prev_q <= scl_i;
        end
    end

    assign edge_o.rise = scl_i & ~scl_prev_q;
    assign edge_o.fall = ~scl_i & scl_prev_q;

endmodule

//--- i2c_xfer_pkg.sv
package i2c_xfer_pkg;

    // Deepest buffer the status level field can report
    localparam int MAX_BUF_DEPTH = 64;
    localparam int LEVEL_W       = $clog2(MAX_BUF_DEPTH + 1);

    // One data byte as seen by the host
    typedef logic [7:0] i2c_byte_t;

    // Transfer request, packs into the address byte as sent on the bus
    typedef struct packed {
        logic [6:0] addr;
        logic       rw;             // 1 = read from slave
    } i2c_cmd_t;

    // --------------------
    // Buffer occupancy
    typedef struct packed {
        logic               full;
        logic               empty;
        logic [LEVEL_W-1:0] level;  // Entries currently stored
    } buf_status_t;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_i2c_master -f vlog.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

//--- tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master
    import i2c_bus_pkg::*;
    import i2c_xfer_pkg::*;
;

    localparam int         CLK_DIV    = 4;
    localparam int         TX_DEPTH   = 4;
    localparam int         RX_DEPTH   = 4;
    localparam int         CLK_NS     = 8;
    localparam logic [6:0] SLAVE_ADDR = 7'h52;
    // Sum over transfers of data bytes plus address and slack
    localparam int         XFER_SLOTS  = 28;
    localparam int         WATCHDOG_NS = XFER_SLOTS * 9 * 2 * CLK_DIV * CLK_NS * 2;
    localparam int         IDLE_LIMIT  = 20 * 9 * 2 * CLK_DIV;

    logic        i2c_core_clk_i;
    logic        reset_ni;
    logic        tx_push_i;
    i2c_byte_t   tx_data_i;
    logic        start_i;
    i2c_cmd_t    cmd_i;
    logic        rx_pop_i;
    i2c_byte_t   rx_data_o;
    logic        rx_valid_o;
    logic        tx_full_o;
    logic        busy_o;
    logic        nack_o;
    i2c_line_t   line_o;
    logic        sda;
    logic        scl;
    logic        slave_sda_oe;
    int          nack_byte;
    int          seed;
    int          errors;
    int          tests;
    int          rd_next;
    logic [7:0]  rd_list [8];
    logic [7:0]  tx_model [$];               // Bytes the TX buffer should hold

    i2c_master_top #(
        .CLK_DIV  (CLK_DIV),
        .TX_DEPTH (TX_DEPTH),
        .RX_DEPTH (RX_DEPTH)
    ) i2c_master_top_i (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .tx_push_i      (tx_push_i),
        .tx_data_i      (tx_data_i),
        .start_i        (start_i),
        .cmd_i          (cmd_i),
        .rx_pop_i       (rx_pop_i),
        .rx_data_o      (rx_data_o),
        .rx_valid_o     (rx_valid_o),
        .tx_full_o      (tx_full_o),
        .busy_o         (busy_o),
        .nack_o         (nack_o),
        .sda_i          (sda),
        .scl_i          (scl),
        .line_o         (line_o)
    );

    tb_i2c_slave_model slave_model (
        .scl_i       (scl),
        .sda_i       (sda),
        .own_addr_i  (SLAVE_ADDR),
        .nack_byte_i (nack_byte),
        .rd_list_i   (rd_list),
        .sda_oe_o    (slave_sda_oe)
    );

    // Wired-AND bus
    assign sda = ~(line_o.sda_oe | slave_sda_oe);
    assign scl = ~line_o.scl_oe;

    always #(CLK_NS / 2) i2c_core_clk_i = ~i2c_core_clk_i;

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: simulation timed out before all tests finished");
        $display(">>> FAIL");
        $finish;
    end

    // --------------------
    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("FAIL %0t ns: %s expected 'h%0h got 'h%0h", $time, name, exp, act);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR %0t ns: %s", $time, msg);
    endtask

    task automatic push_bytes(input int n);
        int rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            @(posedge i2c_core_clk_i);
            tx_push_i <= 1'b1;
            tx_data_i <= rnd[7:0];
            if (tx_model.size() < TX_DEPTH) tx_model.push_back(rnd[7:0]);  // Full drops it
        end
        @(posedge i2c_core_clk_i);
        tx_push_i <= 1'b0;
        @(negedge i2c_core_clk_i);
    endtask

    task automatic start_xfer(input logic [6:0] addr, input logic rw);
        @(posedge i2c_core_clk_i);
        start_i <= 1'b1;
        cmd_i   <= '{addr: addr, rw: rw};
        @(posedge i2c_core_clk_i);
        start_i <= 1'b0;
        @(negedge i2c_core_clk_i);
        if (busy_o !== 1'b1) report_mismatch("busy_o", 32'(1), 32'(busy_o));
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy_o && n < IDLE_LIMIT) begin
            @(negedge i2c_core_clk_i);
            n++;
        end
        if (busy_o) report_problem("transfer never finished, busy_o stuck high");
    endtask

    // Write to addr and check what the slave received
    task automatic run_write(input logic [6:0] addr, input int n_deliver, input logic exp_nack);
        int         base_wr;
        int         base_start;
        int         base_stop;
        logic [7:0] exp;
        base_wr    = slave_model.wr_count;
        base_start = slave_model.start_count;
        base_stop  = slave_model.stop_count;
        start_xfer(addr, 1'b0);
        wait_idle();
        if (slave_model.start_count != base_start + 1) report_problem("slave saw no START");
        if (slave_model.stop_count != base_stop + 1) report_problem("slave saw no STOP");
        if (slave_model.addr_byte !== {addr, 1'b0})
            report_mismatch("address byte", 32'({addr, 1'b0}), 32'(slave_model.addr_byte));
        if (slave_model.wr_count - base_wr != n_deliver)
            report_mismatch("bytes delivered", n_deliver, slave_model.wr_count - base_wr);
        for (int i = 0; i < n_deliver; i++) begin
            exp = tx_model.pop_front();
            if (slave_model.wr_bytes[5'(base_wr + i)] !== exp)
                report_mismatch("written byte", 32'(exp),
                                32'(slave_model.wr_bytes[5'(base_wr + i)]));
        end
        if (nack_o !== exp_nack) report_mismatch("nack_o", 32'(exp_nack), 32'(nack_o));
    endtask

    // --------------------
    task automatic test_reset();
        tests++;
        if (busy_o !== 1'b0) report_mismatch("busy_o", 32'(0), 32'(busy_o));
        if (nack_o !== 1'b0) report_mismatch("nack_o", 32'(0), 32'(nack_o));
        if (rx_valid_o !== 1'b0) report_mismatch("rx_valid_o", 32'(0), 32'(rx_valid_o));
        if (tx_full_o !== 1'b0) report_mismatch("tx_full_o", 32'(0), 32'(tx_full_o));
        if (line_o !== 2'b00) report_mismatch("line_o", 32'(0), 32'(line_o));
    endtask

    task automatic test_write();
        tests++;
        push_bytes(3);
        run_write(SLAVE_ADDR, 3, 1'b0);
    endtask

    task automatic test_buffer_full();
        tests++;
        push_bytes(5);
        if (tx_full_o !== 1'b1) report_mismatch("tx_full_o", 32'(1), 32'(tx_full_o));
        run_write(SLAVE_ADDR, TX_DEPTH, 1'b0);
        if (tx_full_o !== 1'b0) report_mismatch("tx_full_o", 32'(0), 32'(tx_full_o));
    endtask

    task automatic test_address_nack();
        tests++;
        push_bytes(2);
        run_write(SLAVE_ADDR ^ 7'h01, 0, 1'b1);   // Nobody answers
        run_write(SLAVE_ADDR, 2, 1'b0);           // Held bytes go out now
    endtask

    task automatic test_read();
        int base_start;
        int base_stop;
        int base_mnack;
        tests++;
        base_start = slave_model.start_count;
        base_stop  = slave_model.stop_count;
        base_mnack = slave_model.master_nack_count;
        start_xfer(SLAVE_ADDR, 1'b1);
        wait_idle();
        if (slave_model.start_count != base_start + 1) report_problem("slave saw no START");
        if (slave_model.stop_count != base_stop + 1) report_problem("slave saw no STOP");
        if (slave_model.master_nack_count != base_mnack + 1)
            report_problem("master did not NACK the last read byte");
        if (nack_o !== 1'b0) report_mismatch("nack_o", 32'(0), 32'(nack_o));
        for (int i = 0; i < RX_DEPTH; i++) begin
            if (rx_valid_o !== 1'b1) report_mismatch("rx_valid_o", 32'(1), 32'(rx_valid_o));
            if (rx_data_o !== rd_list[rd_next[2:0]])
                report_mismatch("rx_data_o", 32'(rd_list[rd_next[2:0]]), 32'(rx_data_o));
            rd_next++;
            @(posedge i2c_core_clk_i);
            rx_pop_i <= 1'b1;
            @(posedge i2c_core_clk_i);
            rx_pop_i <= 1'b0;
            @(negedge i2c_core_clk_i);
        end
        if (rx_valid_o !== 1'b0) report_mismatch("rx_valid_o", 32'(0), 32'(rx_valid_o));
    endtask

    task automatic test_data_nack();
        tests++;
        nack_byte = slave_model.wr_count + 2;     // Second byte of this write
        push_bytes(3);
        run_write(SLAVE_ADDR, 2, 1'b1);
        nack_byte = 0;
    endtask

    // --------------------
    initial begin
        int rnd;
        i2c_core_clk_i = 1'b0;
        reset_ni       = 1'b0;
        tx_push_i      = 1'b0;
        tx_data_i      = '0;
        start_i        = 1'b0;
        cmd_i          = '0;
        rx_pop_i       = 1'b0;
        nack_byte      = 0;
        seed           = 32'h5653;
        errors         = 0;
        tests          = 0;
        rd_next        = 0;
        for (int i = 0; i < 8; i++) begin
            rnd        = $random(seed);
            rd_list[i] = rnd[7:0];
        end
        repeat (5) @(posedge i2c_core_clk_i);
        reset_ni <= 1'b1;
        @(negedge i2c_core_clk_i);

        test_reset();
        test_write();
        test_buffer_full();
        test_address_nack();
        test_read();
        test_data_nack();

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb_i2c_slave_model.sv
`timescale 1ns/1ps

module tb_i2c_slave_model
    import i2c_bus_pkg::*;
(
    input  logic       scl_i,
    input  logic       sda_i,
    input  logic [6:0] own_addr_i,
    input  int         nack_byte_i,      // Running data byte number to NACK, 0 for none
    input  logic [7:0] rd_list_i [8],    // Bytes returned on reads, in order
    output logic       sda_oe_o
);

    logic [7:0] wr_bytes [32];
    logic [7:0] addr_byte         = 8'h00;
    logic [7:0] shift             = 8'h00;
    logic [7:0] out_byte          = 8'h00;
    logic       drive_low         = 1'b0;
    logic       scl_prev          = 1'b1;
    logic       sda_prev          = 1'b1;
    logic       is_addr           = 1'b0;
    logic       selected          = 1'b0;
    logic       reading           = 1'b0;
    int         bit_cnt           = 0;
    int         wr_count          = 0;
    int         rd_index          = 0;
    int         start_count       = 0;
    int         stop_count        = 0;
    int         master_nack_count = 0;

    assign sda_oe_o = drive_low;

    always @(posedge scl_i or negedge scl_i or posedge sda_i or negedge sda_i) begin
        if (scl_i && scl_prev && sda_prev && !sda_i) begin
            start_count++;                           // START
            bit_cnt   = 0;
            is_addr   = 1'b1;
            selected  = 1'b0;
            reading   = 1'b0;
            drive_low = 1'b0;
        end else if (scl_i && scl_prev && !sda_prev && sda_i) begin
            stop_count++;                            // STOP
            bit_cnt  = 0;
            is_addr  = 1'b0;
            selected = 1'b0;
            reading  = 1'b0;
        end else if (scl_i && !scl_prev) begin
            if (bit_cnt < BITS_PER_BYTE) begin
                shift = {shift[6:0], sda_i};
                bit_cnt++;
                if (bit_cnt == BITS_PER_BYTE && is_addr) begin
                    addr_byte = shift;
                    selected  = (shift[7:1] == own_addr_i);
                    reading   = shift[0];
                end else if (bit_cnt == BITS_PER_BYTE && selected && !reading) begin
                    wr_bytes[wr_count[4:0]] = shift;
                    wr_count++;
                end
            end else begin
                // ACK slot, master answers on reads
                if (reading && selected && !is_addr && sda_i) begin
                    master_nack_count++;
                    selected = 1'b0;
                end
                bit_cnt = BITS_PER_BYTE + 1;
            end
        end else if (!scl_i && scl_prev) begin
            if (bit_cnt == BITS_PER_BYTE) begin
                if (is_addr) begin
                    drive_low = selected;
                end else if (!reading) begin
                    drive_low = selected && (wr_count != nack_byte_i);
                end else begin
                    drive_low = 1'b0;                // Let the master answer
                end
            end else if (bit_cnt == BITS_PER_BYTE + 1) begin
                bit_cnt = 0;
                is_addr = 1'b0;
                if (selected && reading) begin
                    out_byte = rd_list_i[rd_index[2:0]];
                    rd_index++;
                    drive_low = ~out_byte[7];
                end else begin
                    drive_low = 1'b0;
                end
            end else if (bit_cnt > 0 && selected && reading && !is_addr) begin
                drive_low = ~out_byte[7 - bit_cnt];
            end
        end
        scl_prev = scl_i;
        sda_prev = sda_i;
    end

endmodule

//--- vlog.f
i2c_bus_pkg.sv
i2c_xfer_pkg.sv
i2c_scl_gen.sv
i2c_byte_fifo.sv
i2c_master_fsm.sv
i2c_master_top.sv
tb_i2c_slave_model.sv
tb_i2c_master.sv
